//--- verilog/qed_pkg.sv
`default_nettype none

package qed_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned BANK_DEPTH     = 16;
  localparam int unsigned OUT_FIFO_DEPTH = 8;

  typedef logic [$clog2(NUM_BANKS)-1:0]  bank_t;
  typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;

  // a flid is the bank select on top of the entry address
  typedef logic [$bits(bank_t)+$bits(bank_addr_t)-1:0] flid_t;

  typedef logic [31:0] payload_t;
  typedef logic [3:0]  cq_t;

  // one extra bit so that a completely used credit pool still fits
  typedef logic [$clog2(OUT_FIFO_DEPTH):0] credit_cnt_t;

  // ----------------------------------------------------------
  // message fields
  // ----------------------------------------------------------
  typedef enum logic {
    SCH_POP  = 1'b0,
    SCH_READ = 1'b1
  } sch_cmd_t;

  typedef enum logic {
    CLASS_LDB = 1'b0,
    CLASS_DIR = 1'b1
  } sch_class_t;

  typedef enum logic {
    OUT_SCHED  = 1'b0,
    OUT_REPLAY = 1'b1
  } out_cmd_t;

  typedef struct packed {
    flid_t    flid;
    payload_t payload;
  } enq_msg_t;

  typedef struct packed {
    flid_t    flid;
    cq_t      cq;
    sch_cmd_t cmd;
  } sch_msg_t;

  // schedule message tagged with the source it was taken from
  typedef struct packed {
    sch_msg_t   msg;
    sch_class_t sch_class;
  } sch_stage_t;

  typedef struct packed {
    out_cmd_t   cmd;
    sch_class_t sch_class;
    cq_t        cq;
    flid_t      flid;
    payload_t   payload;
  } out_msg_t;

  function automatic bank_t flid_bank(flid_t flid);
    return flid[$bits(flid_t)-1 -: $bits(bank_t)];
  endfunction

  function automatic bank_addr_t flid_addr(flid_t flid);
    return flid[$bits(bank_addr_t)-1:0];
  endfunction

endpackage

`default_nettype wire

//--- verilog/qed_rx_arb.sv
`default_nettype none

module qed_rx_arb (
  input  logic                hqm_gated_clk,
  input  logic                hqm_gated_rst_b,
  input  logic                cfg_req_idlepipe,
  input  logic                enq_valid,
  output logic                enq_ready,
  input  qed_pkg::enq_msg_t   enq_data,
  input  logic                ldb_valid,
  output logic                ldb_ready,
  input  qed_pkg::sch_msg_t   ldb_data,
  input  logic                dir_valid,
  output logic                dir_ready,
  input  qed_pkg::sch_msg_t   dir_data,
  input  logic                crd_afull,
  output logic                enq_take,
  output qed_pkg::enq_msg_t   enq_msg,
  output logic                sch_take,
  output qed_pkg::sch_stage_t sch_stage
);

  // set when dir has priority in the schedule arbiter
  logic sch_prio_dir_q;
  // set when the schedule winner has priority over enqueue
  logic job_prio_sch_q;

  logic req_enq;
  logic req_ldb;
  logic req_dir;
  logic sch_win_v;
  logic sch_win_dir;
  logic job_win_sch;
  logic job_win_enq;
  logic coll_ldb;
  logic coll_dir;
  logic take_enq;
  logic take_ldb0;
  logic take_ldb1;
  logic take_ldb2;
  logic take_dir0;
  logic take_dir1;
  logic take_dir2;
  logic take_ldb;
  logic take_dir;

  // ----------------------------------------------------------
  // requests and the two round-robin winners
  // ----------------------------------------------------------
  assign req_enq = enq_valid;
  assign req_ldb = ldb_valid & ~cfg_req_idlepipe & ~crd_afull;
  assign req_dir = dir_valid & ~cfg_req_idlepipe & ~crd_afull;

  assign sch_win_v   = req_ldb | req_dir;
  assign sch_win_dir = req_dir & (~req_ldb | sch_prio_dir_q);
  assign job_win_sch = sch_win_v & (~req_enq | job_prio_sch_q);
  assign job_win_enq = req_enq & ~job_win_sch;

  assign coll_ldb = req_enq & req_ldb &
                    (qed_pkg::flid_bank(enq_data.flid) == qed_pkg::flid_bank(ldb_data.flid));
  assign coll_dir = req_enq & req_dir &
                    (qed_pkg::flid_bank(enq_data.flid) == qed_pkg::flid_bank(dir_data.flid));

  // ----------------------------------------------------------
  // take decisions
  // ----------------------------------------------------------
  // suffix 0 is the job winner, 1 the loser issued alongside it and
  // 2 the other schedule class when the schedule winner collides
  assign take_enq  = job_win_enq | (job_win_sch & req_enq & ~(sch_win_dir ? coll_dir : coll_ldb));
  assign take_ldb0 = job_win_sch & ~sch_win_dir;
  assign take_ldb1 = job_win_enq & sch_win_v & ~sch_win_dir & ~coll_ldb;
  assign take_ldb2 = job_win_enq & sch_win_dir & coll_dir & req_ldb & ~coll_ldb;
  assign take_dir0 = job_win_sch & sch_win_dir;
  assign take_dir1 = job_win_enq & sch_win_dir & ~coll_dir;
  assign take_dir2 = job_win_enq & sch_win_v & ~sch_win_dir & coll_ldb & req_dir & ~coll_dir;

  assign take_ldb = take_ldb0 | take_ldb1 | take_ldb2;
  assign take_dir = take_dir0 | take_dir1 | take_dir2;

  assign enq_ready = take_enq;
  assign ldb_ready = take_ldb;
  assign dir_ready = take_dir;

  assign enq_take = take_enq;
  assign enq_msg  = enq_data;
  assign sch_take = take_ldb | take_dir;

  always_comb begin
    sch_stage.msg       = take_dir ? dir_data : ldb_data;
    sch_stage.sch_class = take_dir ? qed_pkg::CLASS_DIR : qed_pkg::CLASS_LDB;
  end

  // a fallback take leaves both priorities where they were
  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      sch_prio_dir_q <= 1'b0;
      job_prio_sch_q <= 1'b0;
    end else begin
      if (take_ldb0 | take_ldb1 | take_dir0 | take_dir1) begin
        sch_prio_dir_q <= ~sch_win_dir;
      end
      if (job_win_enq | take_ldb0 | take_dir0) begin
        job_prio_sch_q <= job_win_enq;
      end
    end
  end

  a_one_sch_ready: assert property (@(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_b)
    !(ldb_ready && dir_ready));

  a_no_take_without_credit: assert property (@(posedge hqm_gated_clk)
    disable iff (!hqm_gated_rst_b) !(sch_take && crd_afull));

endmodule

`default_nettype wire

//--- verilog/qed_bank_store.sv
`default_nettype none

module qed_bank_store (
  input  logic                hqm_gated_clk,
  input  logic                hqm_gated_rst_b,
  input  logic                enq_take,
  input  qed_pkg::enq_msg_t   enq_msg,
  input  logic                sch_take,
  input  qed_pkg::sch_stage_t sch_stage,
  output logic                push,
  output qed_pkg::out_msg_t   push_data,
  output logic                pipe_idle
);

  logic                p0_enq_v_q;
  qed_pkg::enq_msg_t   p0_enq_q;
  logic                p0_sch_v_q;
  qed_pkg::sch_stage_t p0_sch_q;
  logic                p1_sch_v_q;
  qed_pkg::sch_stage_t p1_sch_q;
  logic                p2_sch_v_q;
  qed_pkg::sch_stage_t p2_sch_q;
  qed_pkg::payload_t   p2_data_q;

  logic [qed_pkg::NUM_BANKS-1:0] bank_we;
  logic [qed_pkg::NUM_BANKS-1:0] bank_re;
  qed_pkg::bank_addr_t           wr_addr;
  qed_pkg::bank_addr_t           rd_addr;
  qed_pkg::payload_t             bank_rdata_q [qed_pkg::NUM_BANKS];

  // ----------------------------------------------------------
  // stage valids
  // ----------------------------------------------------------
  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      p0_enq_v_q <= 1'b0;
      p0_sch_v_q <= 1'b0;
      p1_sch_v_q <= 1'b0;
      p2_sch_v_q <= 1'b0;
    end else begin
      p0_enq_v_q <= enq_take;
      p0_sch_v_q <= sch_take;
      p1_sch_v_q <= p0_sch_v_q;
      p2_sch_v_q <= p1_sch_v_q;
    end
  end

  always_ff @(posedge hqm_gated_clk) begin
    if (enq_take) begin
      p0_enq_q <= enq_msg;
    end
    if (sch_take) begin
      p0_sch_q <= sch_stage;
    end
    if (p0_sch_v_q) begin
      p1_sch_q <= p0_sch_q;
    end
    // read data comes out of the bank one cycle after the address
    if (p1_sch_v_q) begin
      p2_sch_q  <= p1_sch_q;
      p2_data_q <= bank_rdata_q[qed_pkg::flid_bank(p1_sch_q.msg.flid)];
    end
  end

  // ----------------------------------------------------------
  // storage banks
  // ----------------------------------------------------------
  assign wr_addr = qed_pkg::flid_addr(p0_enq_q.flid);
  assign rd_addr = qed_pkg::flid_addr(p0_sch_q.msg.flid);

  for (genvar b = 0; b < qed_pkg::NUM_BANKS; b++) begin : g_bank
    qed_pkg::payload_t mem_q [qed_pkg::BANK_DEPTH];

    assign bank_we[b] = p0_enq_v_q &
                        (qed_pkg::flid_bank(p0_enq_q.flid) == qed_pkg::bank_t'(b));
    assign bank_re[b] = p0_sch_v_q &
                        (qed_pkg::flid_bank(p0_sch_q.msg.flid) == qed_pkg::bank_t'(b));

    always_ff @(posedge hqm_gated_clk) begin
      if (bank_we[b]) begin
        mem_q[wr_addr] <= p0_enq_q.payload;
      end
      if (bank_re[b]) begin
        bank_rdata_q[b] <= mem_q[rd_addr];
      end
    end
  end

  // ----------------------------------------------------------
  // output message
  // ----------------------------------------------------------
  assign push = p2_sch_v_q;

  always_comb begin
    if (p2_sch_q.msg.cmd == qed_pkg::SCH_READ) begin
      push_data.cmd = qed_pkg::OUT_REPLAY;
    end else begin
      push_data.cmd = qed_pkg::OUT_SCHED;
    end
    push_data.sch_class = p2_sch_q.sch_class;
    push_data.cq        = p2_sch_q.msg.cq;
    push_data.flid      = p2_sch_q.msg.flid;
    push_data.payload   = p2_data_q;
  end

  assign pipe_idle = ~(p0_enq_v_q | p0_sch_v_q | p1_sch_v_q | p2_sch_v_q);

  // the bank check at the input side keeps an enqueue and a schedule
  // that were issued together out of the same bank
  a_no_bank_rw_clash: assert property (@(posedge hqm_gated_clk)
    disable iff (!hqm_gated_rst_b) (bank_we & bank_re) == '0);

endmodule

`default_nettype wire

//--- verilog/qed_out_fifo.sv
`default_nettype none

module qed_out_fifo (
  input  logic              hqm_gated_clk,
  input  logic              hqm_gated_rst_b,
  input  logic              push,
  input  qed_pkg::out_msg_t push_data,
  input  logic              sch_take,
  input  logic              pipe_idle,
  input  logic              out_ready,
  output logic              out_valid,
  output qed_pkg::out_msg_t out_data,
  output logic              crd_afull,
  output logic              idle
);

  typedef logic [$clog2(qed_pkg::OUT_FIFO_DEPTH)-1:0] fifo_ptr_t;

  qed_pkg::out_msg_t    fifo_mem [qed_pkg::OUT_FIFO_DEPTH];
  fifo_ptr_t            wr_ptr_q;
  fifo_ptr_t            rd_ptr_q;
  qed_pkg::credit_cnt_t fifo_cnt_q;
  qed_pkg::credit_cnt_t crd_q;
  logic                 fifo_empty;
  logic                 fifo_full;
  logic                 pop;

  // ----------------------------------------------------------
  // FIFO
  // ----------------------------------------------------------
  assign fifo_empty = (fifo_cnt_q == '0);
  assign fifo_full  = (fifo_cnt_q == qed_pkg::credit_cnt_t'(qed_pkg::OUT_FIFO_DEPTH));
  assign pop        = out_valid & out_ready;

  always_ff @(posedge hqm_gated_clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= push_data;
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
      end
      if (push && !pop) begin
        fifo_cnt_q <= fifo_cnt_q + qed_pkg::credit_cnt_t'(1);
      end else if (!push && pop) begin
        fifo_cnt_q <= fifo_cnt_q - qed_pkg::credit_cnt_t'(1);
      end
    end
  end

  assign out_valid = ~fifo_empty;
  assign out_data  = fifo_mem[rd_ptr_q];

  // ----------------------------------------------------------
  // credits
  // ----------------------------------------------------------
  // a credit covers a schedule from acceptance until it leaves the FIFO
  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      crd_q <= '0;
    end else if (sch_take && !pop) begin
      crd_q <= crd_q + qed_pkg::credit_cnt_t'(1);
    end else if (!sch_take && pop) begin
      crd_q <= crd_q - qed_pkg::credit_cnt_t'(1);
    end
  end

  assign crd_afull = (crd_q == qed_pkg::credit_cnt_t'(qed_pkg::OUT_FIFO_DEPTH));
  assign idle      = pipe_idle & fifo_empty & (crd_q == '0);

  a_no_push_when_full: assert property (@(posedge hqm_gated_clk)
    disable iff (!hqm_gated_rst_b) push |-> !fifo_full);

  a_no_crd_underflow: assert property (@(posedge hqm_gated_clk)
    disable iff (!hqm_gated_rst_b) pop |-> (crd_q != '0));

endmodule

`default_nettype wire

//--- verilog/qed_pipe.sv
`default_nettype none

module qed_pipe (
  input  logic              hqm_gated_clk,
  input  logic              hqm_gated_rst_b,
  input  logic              cfg_req_idlepipe,
  input  logic              enq_valid,
  output logic              enq_ready,
  input  qed_pkg::enq_msg_t enq_data,
  input  logic              ldb_valid,
  output logic              ldb_ready,
  input  qed_pkg::sch_msg_t ldb_data,
  input  logic              dir_valid,
  output logic              dir_ready,
  input  qed_pkg::sch_msg_t dir_data,
  output logic              out_valid,
  input  logic              out_ready,
  output qed_pkg::out_msg_t out_data,
  output logic              idle
);

  logic                enq_take;
  qed_pkg::enq_msg_t   enq_msg;
  logic                sch_take;
  qed_pkg::sch_stage_t sch_stage;
  logic                crd_afull;
  logic                push;
  qed_pkg::out_msg_t   push_data;
  logic                pipe_idle;

  qed_rx_arb i_rx_arb (
    .hqm_gated_clk    (hqm_gated_clk),
    .hqm_gated_rst_b  (hqm_gated_rst_b),
    .cfg_req_idlepipe (cfg_req_idlepipe),
    .enq_valid        (enq_valid),
    .enq_ready        (enq_ready),
    .enq_data         (enq_data),
    .ldb_valid        (ldb_valid),
    .ldb_ready        (ldb_ready),
    .ldb_data         (ldb_data),
    .dir_valid        (dir_valid),
    .dir_ready        (dir_ready),
    .dir_data         (dir_data),
    .crd_afull        (crd_afull),
    .enq_take         (enq_take),
    .enq_msg          (enq_msg),
    .sch_take         (sch_take),
    .sch_stage        (sch_stage)
  );

  qed_bank_store i_bank_store (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_b (hqm_gated_rst_b),
    .enq_take        (enq_take),
    .enq_msg         (enq_msg),
    .sch_take        (sch_take),
    .sch_stage       (sch_stage),
    .push            (push),
    .push_data       (push_data),
    .pipe_idle       (pipe_idle)
  );

  qed_out_fifo i_out_fifo (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_b (hqm_gated_rst_b),
    .push            (push),
    .push_data       (push_data),
    .sch_take        (sch_take),
    .pipe_idle       (pipe_idle),
    .out_ready       (out_ready),
    .out_valid       (out_valid),
    .out_data        (out_data),
    .crd_afull       (crd_afull),
    .idle            (idle)
  );

endmodule

`default_nettype wire

//--- verification/qed_tb_util.svh
`ifndef QED_TB_UTIL_SVH
`define QED_TB_UTIL_SVH
`default_nettype none

// ------------------------------------------------------------
// checks
// ------------------------------------------------------------
task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
  end
endtask

task automatic report_failure(input string what);
  err_count++;
  $display("%0t ns: %s", $time, what);
endtask

// 32-bit Galois LFSR for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

// ------------------------------------------------------------
// bounded waits
// ------------------------------------------------------------
task automatic sample_point();
  #(SMP - DRV);
endtask

task automatic next_drive();
  @(posedge hqm_gated_clk);
  #(DRV);
endtask

function automatic logic ready_of(input int port);
  case (port)
    P_ENQ:   return enq_ready;
    P_LDB:   return ldb_ready;
    P_DIR:   return dir_ready;
    default: return ldb_ready | dir_ready;
  endcase
endfunction

// entered and left at a drive point and sets ok when the handshake happened
task automatic wait_ready(input int port, input int limit, output bit ok);
  ok = 1'b0;
  for (int n = 0; n < limit && !ok; n++) begin
    sample_point();
    ok = ready_of(port);
    next_drive();
  end
endtask

task automatic wait_drain();
  int n;
  n = 0;
  while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
    next_drive();
    n++;
  end
  if (exp_q.size() != 0) begin
    report_failure("expected outputs never arrived");
  end
endtask

task automatic wait_idle(output bit ok);
  ok = 1'b0;
  for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
    sample_point();
    ok = idle;
    next_drive();
  end
endtask

`default_nettype wire
`endif

//--- verification/qed_pipe_tb.sv
`default_nettype none

module qed_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 40;
  localparam int DRV         = 2;
  localparam int SMP         = 38;
  localparam int WAIT_LIMIT  = 50;
  localparam int DRAIN_LIMIT = 200;
  localparam int P_ENQ       = 0;
  localparam int P_LDB       = 1;
  localparam int P_DIR       = 2;
  localparam int P_SCH       = 3;

  logic              hqm_gated_clk;
  logic              hqm_gated_rst_b;
  logic              cfg_req_idlepipe;
  logic              enq_valid;
  logic              enq_ready;
  qed_pkg::enq_msg_t enq_data;
  logic              ldb_valid;
  logic              ldb_ready;
  qed_pkg::sch_msg_t ldb_data;
  logic              dir_valid;
  logic              dir_ready;
  qed_pkg::sch_msg_t dir_data;
  logic              out_valid;
  logic              out_ready;
  qed_pkg::out_msg_t out_data;
  logic              idle;

  int                  err_count;
  int                  check_count;
  int                  test_count;
  int                  out_cnt;
  logic [31:0]         lfsr_state;
  qed_pkg::payload_t   model [1 << $bits(qed_pkg::flid_t)];
  qed_pkg::out_msg_t   exp_q [$];
  qed_pkg::sch_class_t acc_class_q [$];
  qed_pkg::out_msg_t   exp_msg;
  logic                stalled;
  qed_pkg::out_msg_t   stalled_msg;

  qed_pipe qed_pipe_inst (.*);

  always #(CLK_PERIOD / 2) hqm_gated_clk = ~hqm_gated_clk;

  // ------------------------------------------------------------
  // monitor sampling just before each rising edge
  // ------------------------------------------------------------
  always begin
    @(posedge hqm_gated_clk);
    #(SMP);
    if (!hqm_gated_rst_b) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        check("out_valid", 64'(out_valid), 64'(1));
        check("out_data held", 64'(out_data), 64'(stalled_msg));
      end
      if (enq_valid && enq_ready) begin
        model[enq_data.flid] = enq_data.payload;
      end
      if (ldb_valid && ldb_ready) begin
        note_schedule(ldb_data, qed_pkg::CLASS_LDB);
      end
      if (dir_valid && dir_ready) begin
        note_schedule(dir_data, qed_pkg::CLASS_DIR);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("an output arrived with no schedule pending");
        end else begin
          exp_msg = exp_q.pop_front();
          check("out_data", 64'(out_data), 64'(exp_msg));
        end
        out_cnt++;
      end
      stalled     = out_valid & ~out_ready;
      stalled_msg = out_data;
    end
  end

  // builds the output that a schedule must produce as it is accepted
  function automatic void note_schedule(input qed_pkg::sch_msg_t m,
                                        input qed_pkg::sch_class_t c);
    qed_pkg::out_msg_t e;
    e.cmd       = (m.cmd == qed_pkg::SCH_READ) ? qed_pkg::OUT_REPLAY : qed_pkg::OUT_SCHED;
    e.sch_class = c;
    e.cq        = m.cq;
    e.flid      = m.flid;
    e.payload   = model[m.flid];
    exp_q.push_back(e);
    acc_class_q.push_back(c);
  endfunction

  // ------------------------------------------------------------
  // drivers
  // ------------------------------------------------------------
  function automatic qed_pkg::sch_msg_t make_sch(input qed_pkg::flid_t f,
                                                 input qed_pkg::sch_cmd_t cmd);
    qed_pkg::sch_msg_t m;
    m.flid = f;
    m.cq   = qed_pkg::cq_t'(rand_bits(4));
    m.cmd  = cmd;
    return m;
  endfunction

  function automatic qed_pkg::flid_t pick_flid(input int bank);
    return {qed_pkg::bank_t'(bank), qed_pkg::bank_addr_t'(rand_bits(4))};
  endfunction

  task automatic drive_sch(input int port, input qed_pkg::sch_msg_t m);
    if (port == P_LDB) begin
      ldb_data  = m;
      ldb_valid = 1'b1;
    end else begin
      dir_data  = m;
      dir_valid = 1'b1;
    end
  endtask

  task automatic send_enq(input qed_pkg::flid_t f, input qed_pkg::payload_t payload);
    bit ok;
    enq_data.flid    = f;
    enq_data.payload = payload;
    enq_valid        = 1'b1;
    wait_ready(P_ENQ, WAIT_LIMIT, ok);
    enq_valid = 1'b0;
    if (!ok) begin
      report_failure("an enqueue was never accepted");
    end
  endtask

  task automatic send_sch(input int port, input qed_pkg::sch_msg_t m);
    bit ok;
    drive_sch(port, m);
    wait_ready(port, WAIT_LIMIT, ok);
    if (port == P_LDB) begin
      ldb_valid = 1'b0;
    end else begin
      dir_valid = 1'b0;
    end
    if (!ok) begin
      report_failure("a schedule was never accepted");
    end
  endtask

  task automatic fill_store();
    for (int f = 0; f < (1 << $bits(qed_pkg::flid_t)); f++) begin
      send_enq(qed_pkg::flid_t'(f), rand_bits(32));
    end
  endtask

  task automatic apply_reset();
    enq_valid        = 1'b0;
    ldb_valid        = 1'b0;
    dir_valid        = 1'b0;
    cfg_req_idlepipe = 1'b0;
    out_ready        = 1'b1;
    hqm_gated_rst_b  = 1'b0;
    exp_q.delete();
    acc_class_q.delete();
    repeat (4) @(posedge hqm_gated_clk);
    #(DRV);
    hqm_gated_rst_b = 1'b1;
    sample_point();
    check("out_valid after reset", 64'(out_valid), 64'(0));
    check("idle after reset", 64'(idle), 64'(1));
    check("readies after reset", 64'({enq_ready, ldb_ready, dir_ready}), 64'(0));
    next_drive();
  endtask

  task automatic end_test(input string name, input int e0);
    test_count++;
    $display("%s: done, %0d errors", name, err_count - e0);
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic write_then_replay();
    int             e0;
    int             o0;
    qed_pkg::flid_t f;
    e0 = err_count;
    o0 = out_cnt;
    fill_store();
    for (int k = 0; k < 6; k++) begin
      f = qed_pkg::flid_t'(rand_bits(6));
      send_sch(P_LDB, make_sch(f, qed_pkg::SCH_READ));
      send_sch(P_DIR, make_sch(f, qed_pkg::SCH_READ));
      send_enq(f, rand_bits(32));
      send_sch(P_DIR, make_sch(f, qed_pkg::SCH_READ));
    end
    wait_drain();
    check("replay outputs", 64'(out_cnt - o0), 64'(18));
    end_test("write then replay", e0);
  endtask

  task automatic random_pops();
    int             e0;
    int             o0;
    qed_pkg::flid_t f;
    e0 = err_count;
    o0 = out_cnt;
    for (int k = 0; k < 40; k++) begin
      f = qed_pkg::flid_t'(rand_bits(6));
      send_enq(f, rand_bits(32));
      send_sch(rand_bits(1) ? P_DIR : P_LDB, make_sch(f, qed_pkg::SCH_POP));
    end
    wait_drain();
    check("pop outputs", 64'(out_cnt - o0), 64'(40));
    end_test("random pops", e0);
  endtask

  task automatic dual_issue();
    int e0;
    bit ok;
    bit enq_first;
    e0 = err_count;
    enq_data.flid    = pick_flid(0);
    enq_data.payload = rand_bits(32);
    enq_valid        = 1'b1;
    drive_sch(P_LDB, make_sch(pick_flid(1), qed_pkg::SCH_POP));
    sample_point();
    check("enq_ready", 64'(enq_ready), 64'(1));
    check("ldb_ready", 64'(ldb_ready), 64'(1));
    next_drive();
    enq_valid = 1'b0;
    ldb_valid = 1'b0;

    // on the same bank only one of the two may go
    enq_data.flid    = pick_flid(2);
    enq_data.payload = rand_bits(32);
    enq_valid        = 1'b1;
    drive_sch(P_LDB, make_sch(pick_flid(2), qed_pkg::SCH_POP));
    sample_point();
    check("readies on a bank collision", 64'(int'(enq_ready) + int'(ldb_ready)), 64'(1));
    enq_first = enq_ready;
    next_drive();
    if (enq_first) begin
      enq_valid = 1'b0;
      wait_ready(P_LDB, WAIT_LIMIT, ok);
    end else begin
      ldb_valid = 1'b0;
      wait_ready(P_ENQ, WAIT_LIMIT, ok);
    end
    enq_valid = 1'b0;
    ldb_valid = 1'b0;
    if (!ok) begin
      report_failure("the request that lost the bank collision was never accepted");
    end

    // a lone dir take leaves ldb and enqueue with priority
    send_sch(P_DIR, make_sch(pick_flid(1), qed_pkg::SCH_POP));
    enq_data.flid    = pick_flid(3);
    enq_data.payload = rand_bits(32);
    enq_valid        = 1'b1;
    drive_sch(P_LDB, make_sch(pick_flid(3), qed_pkg::SCH_POP));
    drive_sch(P_DIR, make_sch(pick_flid(0), qed_pkg::SCH_POP));
    sample_point();
    check("enq_ready", 64'(enq_ready), 64'(1));
    check("dir_ready", 64'(dir_ready), 64'(1));
    check("ldb_ready", 64'(ldb_ready), 64'(0));
    next_drive();
    enq_valid = 1'b0;
    dir_valid = 1'b0;
    wait_ready(P_LDB, WAIT_LIMIT, ok);
    ldb_valid = 1'b0;
    if (!ok) begin
      report_failure("the colliding ldb schedule was never accepted");
    end
    wait_drain();
    end_test("dual issue and collision", e0);
  endtask

  task automatic round_robin();
    int e0;
    int n;
    e0 = err_count;
    wait_drain();
    apply_reset();
    fill_store();
    drive_sch(P_LDB, make_sch(qed_pkg::flid_t'(rand_bits(6)), qed_pkg::SCH_POP));
    drive_sch(P_DIR, make_sch(qed_pkg::flid_t'(rand_bits(6)), qed_pkg::SCH_POP));
    n = 0;
    while (acc_class_q.size() < 8 && n < WAIT_LIMIT) begin
      next_drive();
      n++;
    end
    ldb_valid = 1'b0;
    dir_valid = 1'b0;
    if (acc_class_q.size() < 8) begin
      report_failure("held schedules were not accepted in time");
    end
    for (int i = 0; i < acc_class_q.size(); i++) begin
      check("accepted class", 64'(acc_class_q[i]),
            64'((i % 2) ? qed_pkg::CLASS_DIR : qed_pkg::CLASS_LDB));
    end
    wait_drain();
    end_test("round robin", e0);
  endtask

  task automatic back_pressure();
    int e0;
    int o0;
    int acc;
    bit ok;
    e0        = err_count;
    o0        = out_cnt;
    acc       = 0;
    ok        = 1'b1;
    out_ready = 1'b0;
    drive_sch(P_LDB, make_sch(qed_pkg::flid_t'(rand_bits(6)), qed_pkg::SCH_POP));
    while (ok && acc < 12) begin
      wait_ready(P_LDB, 20, ok);
      if (ok) begin
        acc++;
        ldb_data = make_sch(qed_pkg::flid_t'(rand_bits(6)), qed_pkg::SCH_POP);
      end
    end
    check("accepted while stalled", 64'(acc), 64'(qed_pkg::OUT_FIFO_DEPTH));
    check("out_valid while stalled", 64'(out_valid), 64'(1));
    out_ready = 1'b1;
    ok        = 1'b1;
    while (ok && acc < 12) begin
      wait_ready(P_LDB, WAIT_LIMIT, ok);
      if (ok) begin
        acc++;
        ldb_data = make_sch(qed_pkg::flid_t'(rand_bits(6)), qed_pkg::SCH_POP);
      end
    end
    ldb_valid = 1'b0;
    if (!ok) begin
      report_failure("schedules stayed blocked after out_ready rose");
    end
    wait_drain();
    check("outputs after stall", 64'(out_cnt - o0), 64'(12));
    end_test("back-pressure", e0);
  endtask

  task automatic hold_and_idle();
    int e0;
    bit ok;
    e0        = err_count;
    out_ready = 1'b0;
    for (int k = 0; k < 3; k++) begin
      send_sch(P_LDB, make_sch(qed_pkg::flid_t'(rand_bits(6)), qed_pkg::SCH_POP));
    end
    cfg_req_idlepipe = 1'b1;
    drive_sch(P_LDB, make_sch(qed_pkg::flid_t'(rand_bits(6)), qed_pkg::SCH_POP));
    drive_sch(P_DIR, make_sch(qed_pkg::flid_t'(rand_bits(6)), qed_pkg::SCH_POP));
    wait_ready(P_SCH, 10, ok);
    if (ok) begin
      report_failure("a schedule was accepted while the pipe hold was set");
    end
    check("idle with outputs pending", 64'(idle), 64'(0));
    ldb_valid        = 1'b0;
    dir_valid        = 1'b0;
    cfg_req_idlepipe = 1'b0;
    out_ready        = 1'b1;
    wait_drain();
    wait_idle(ok);
    if (!ok) begin
      report_failure("the pipe did not report idle after draining");
    end
    end_test("hold and idle", e0);
  endtask

  initial begin
    hqm_gated_clk    = 1'b0;
    hqm_gated_rst_b  = 1'b0;
    cfg_req_idlepipe = 1'b0;
    enq_valid        = 1'b0;
    enq_data         = '0;
    ldb_valid        = 1'b0;
    ldb_data         = '0;
    dir_valid        = 1'b0;
    dir_data         = '0;
    out_ready        = 1'b1;
    err_count        = 0;
    check_count      = 0;
    test_count       = 0;
    out_cnt          = 0;
    stalled          = 1'b0;
    lfsr_state       = 32'ha160;
    apply_reset();
    write_then_replay();
    random_pops();
    dual_issue();
    round_robin();
    back_pressure();
    hold_and_idle();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

`include "qed_tb_util.svh"

endmodule

`default_nettype wire

//--- list.f
+incdir+verification
verilog/qed_pkg.sv
verilog/qed_rx_arb.sv
verilog/qed_bank_store.sv
verilog/qed_out_fifo.sv
verilog/qed_pipe.sv
verification/qed_pipe_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = qed_pipe_tb
FILELIST  = list.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
